//--- src/rvfi_mon_trace_pkg.sv
package rvfi_mon_trace_pkg;

  // Number of violation kinds, which is also the width of every violation vector
  parameter int NUM_VIOL = 6;

  // Exception cause width in the trap record and in the low bits of mcause
  parameter int EXC_CAUSE_W = 6;

  // Debug entry cause, encoded the same way as dcsr.cause
  typedef enum logic [2:0] {
    NONE    = 3'd0,
    EBREAK  = 3'd1,
    TRIGGER = 3'd2,
    HALTREQ = 3'd3,
    STEP    = 3'd4
  } dbg_cause_e;

  // Bit position of each check in the violation vectors and in REG_STATUS
  typedef enum logic [2:0] {
    TRAP_NO_INTR       = 3'd0,
    MCAUSE_MISMATCH    = 3'd1,
    DBG_CAUSE_MISMATCH = 3'd2,
    STEP_CAUSE_BAD     = 3'd3,
    DBG_NO_ACK         = 3'd4,
    IRQ_NO_INTR        = 3'd5
  } viol_kind_e;

endpackage

//--- src/rvfi_mon_reg_pkg.sv
package rvfi_mon_reg_pkg;

  //////////////////////////////////////////////////
  // Register map, byte addresses on the 8-bit bus
  //////////////////////////////////////////////////

  parameter logic [7:0] REG_STATUS     = 8'h00;
  parameter logic [7:0] REG_VIOL_CNT   = 8'h04;
  parameter logic [7:0] REG_RETIRE_CNT = 8'h08;
  parameter logic [7:0] REG_FIRST_PC   = 8'h0C;
  parameter logic [7:0] REG_FIRST_KIND = 8'h10;
  // Write-only, the data is ignored
  parameter logic [7:0] REG_CLEAR      = 8'h14;

  // Response codes on bresp and rresp
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2
  } axi_resp_e;

  // Slave FSM, one transaction in flight at a time
  typedef enum logic [1:0] {
    IDLE,
    RDATA,
    WRESP
  } axil_state_e;

endpackage

//--- src/rvfi_trap_checker.sv
`timescale 1ns/1ps

module rvfi_trap_checker #(
  parameter bit DEBUG = 1'b1
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       rvfi_valid_i,
  input  logic                                       rvfi_intr_i,
  input  logic                                       rvfi_trap_exc_i,
  input  logic                                       rvfi_trap_dbg_i,
  input  logic [rvfi_mon_trace_pkg::EXC_CAUSE_W-1:0] rvfi_trap_cause_i,
  input  logic [2:0]                                 rvfi_trap_dbg_cause_i,
  input  logic [2:0]                                 rvfi_dbg_i,
  input  logic [rvfi_mon_trace_pkg::EXC_CAUSE_W-1:0] rvfi_mcause_i,
  input  logic                                       debug_mode_i,
  input  logic                                       dcsr_step_i,
  input  logic                                       nmi_pending_i,
  output logic [rvfi_mon_trace_pkg::NUM_VIOL-1:0]    viol_o
);
  import rvfi_mon_trace_pkg::*;

  // Trap record of the last valid retirement
  logic                   trap_exc_q;
  logic                   trap_dbg_q;
  logic [EXC_CAUSE_W-1:0] trap_cause_q;
  dbg_cause_e             trap_dbg_cause_q;

  // Debug mode, single step or a pending NMI seen since that retirement
  logic                   exempt_q;
  logic                   exempt_cond;
  logic                   exempt_now;
  logic [NUM_VIOL-1:0]    viol_d;

  // The exemption window includes both retirements and every cycle between them
  assign exempt_cond = debug_mode_i | dcsr_step_i | nmi_pending_i;
  assign exempt_now  = exempt_q | exempt_cond;

  //////////////////////////////////////////////////
  // Previous trap record and exemption window
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_exc_q       <= 1'b0;
      trap_dbg_q       <= 1'b0;
      trap_cause_q     <= '0;
      trap_dbg_cause_q <= NONE;
      exempt_q         <= 1'b0;
    end else if (rvfi_valid_i) begin
      trap_exc_q       <= rvfi_trap_exc_i;
      trap_dbg_q       <= rvfi_trap_dbg_i;
      trap_cause_q     <= rvfi_trap_cause_i;
      trap_dbg_cause_q <= dbg_cause_e'(rvfi_trap_dbg_cause_i);
      // A new window starts with this retirement
      exempt_q         <= exempt_cond;
    end else begin
      exempt_q         <= exempt_now;
    end
  end

  //////////////////////////////////////////////////
  // Checks, evaluated on each valid retirement
  //////////////////////////////////////////////////

  always_comb begin
    viol_d = '0;
    if (rvfi_valid_i) begin
      // Any trap must be taken as an interrupt-flagged retirement
      viol_d[TRAP_NO_INTR]    = (trap_exc_q || trap_dbg_q) && !exempt_now && !rvfi_intr_i;
      // An exception trap must show up as the same cause in mcause
      viol_d[MCAUSE_MISMATCH] = trap_exc_q && !exempt_now &&
                                (rvfi_mcause_i != trap_cause_q);
      // The debug cause of a debug trap carries over into rvfi_dbg
      viol_d[DBG_CAUSE_MISMATCH] = DEBUG && trap_dbg_q &&
                                   (rvfi_dbg_i != trap_dbg_cause_q);
      // Exception and debug together is only legal during single step
      viol_d[STEP_CAUSE_BAD] = DEBUG && rvfi_trap_exc_i && rvfi_trap_dbg_i &&
                               (dbg_cause_e'(rvfi_trap_dbg_cause_i) != STEP);
    end
  end

  // One-cycle registered pulse per violation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol_o <= '0;
    end else begin
      viol_o <= viol_d;
    end
  end

  // Every pulse belongs to a retirement one cycle earlier
  a_viol_follows_retire: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|viol_o) |-> $past(rvfi_valid_i))
    else $error("trap checker pulsed a violation without a retirement");

endmodule

//--- src/rvfi_ack_tracker.sv
`timescale 1ns/1ps

module rvfi_ack_tracker #(
  parameter bit DEBUG = 1'b1
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    rvfi_valid_i,
  input  logic                                    rvfi_intr_i,
  input  logic [2:0]                              rvfi_dbg_i,
  input  logic                                    irq_ack_i,
  input  logic                                    dbg_ack_i,
  output logic [rvfi_mon_trace_pkg::NUM_VIOL-1:0] viol_o
);
  import rvfi_mon_trace_pkg::*;

  // Debug acknowledges not yet consumed by a debug entry
  logic [1:0]          dbg_cnt_q;
  // Interrupt acknowledged, waiting for the next retirement
  logic                irq_pend_q;
  logic                dbg_ret;
  logic [NUM_VIOL-1:0] viol_d;

  // A retirement that reports a debug entry
  assign dbg_ret = rvfi_valid_i && (rvfi_dbg_i != NONE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dbg_cnt_q  <= 2'd0;
      irq_pend_q <= 1'b0;
    end else begin
      // Ack and entry in the same cycle cancel out
      if (dbg_ack_i && !dbg_ret) begin
        dbg_cnt_q <= dbg_cnt_q + 2'd1;
      end else if (dbg_ret && !dbg_ack_i && (dbg_cnt_q != 2'd0)) begin
        dbg_cnt_q <= dbg_cnt_q - 2'd1;
      end
      // The retirement that answers an ack comes at least one cycle later
      if (irq_ack_i) begin
        irq_pend_q <= 1'b1;
      end else if (rvfi_valid_i) begin
        irq_pend_q <= 1'b0;
      end
    end
  end

  always_comb begin
    viol_d = '0;
    viol_d[DBG_NO_ACK]  = DEBUG && dbg_ret && (dbg_cnt_q == 2'd0);
    viol_d[IRQ_NO_INTR] = rvfi_valid_i && irq_pend_q && !rvfi_intr_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol_o <= '0;
    end else begin
      viol_o <= viol_d;
    end
  end

  // The core never has more than three debug acks in flight
  a_dbg_cnt_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dbg_cnt_q == 2'd3) |=> (dbg_cnt_q != 2'd0))
    else $error("outstanding debug ack count wrapped");

endmodule

//--- src/rvfi_violation_log.sv
`timescale 1ns/1ps

module rvfi_violation_log #(
  parameter int CNT_W = 16
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic [rvfi_mon_trace_pkg::NUM_VIOL-1:0] viol_i,
  input  logic                                    retire_i,
  input  logic [31:0]                             pc_i,
  input  logic                                    clear_i,
  output logic [rvfi_mon_trace_pkg::NUM_VIOL-1:0] status_o,
  output logic [CNT_W-1:0]                        viol_cnt_o,
  output logic [CNT_W-1:0]                        retire_cnt_o,
  output logic [31:0]                             first_pc_o,
  output rvfi_mon_trace_pkg::viol_kind_e          first_kind_o,
  output logic                                    first_valid_o
);
  import rvfi_mon_trace_pkg::*;

  localparam int SET_W = $clog2(NUM_VIOL + 1);

  // Retirement delayed one stage so that it lines up with the violation pulses
  logic             retire_q;
  logic [31:0]      pc_q;
  logic [SET_W-1:0] n_set;
  viol_kind_e       low_kind;
  logic [CNT_W:0]   viol_sum;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_q <= 1'b0;
    end else begin
      retire_q <= retire_i;
    end
  end

  always_ff @(posedge clk_i) begin
    pc_q <= pc_i;
  end

  // Number of kinds set this cycle and the lowest of them
  always_comb begin
    n_set    = '0;
    low_kind = TRAP_NO_INTR;
    for (int i = NUM_VIOL - 1; i >= 0; i--) begin
      if (viol_i[i]) begin
        n_set    = n_set + SET_W'(1);
        low_kind = viol_kind_e'(i);
      end
    end
  end

  // One spare bit catches the overflow for saturation
  assign viol_sum = {1'b0, viol_cnt_o} + (CNT_W + 1)'(n_set);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_o      <= '0;
      viol_cnt_o    <= '0;
      retire_cnt_o  <= '0;
      first_pc_o    <= '0;
      first_kind_o  <= TRAP_NO_INTR;
      first_valid_o <= 1'b0;
    end else if (clear_i) begin
      status_o      <= '0;
      viol_cnt_o    <= '0;
      retire_cnt_o  <= '0;
      first_pc_o    <= '0;
      first_kind_o  <= TRAP_NO_INTR;
      first_valid_o <= 1'b0;
    end else begin
      status_o   <= status_o | viol_i;
      viol_cnt_o <= viol_sum[CNT_W] ? '1 : viol_sum[CNT_W-1:0];
      if (retire_q && (retire_cnt_o != '1)) begin
        retire_cnt_o <= retire_cnt_o + 1'b1;
      end
      // Only the first failing cycle is kept
      if (!first_valid_o && (|viol_i)) begin
        first_pc_o    <= pc_q;
        first_kind_o  <= low_kind;
        first_valid_o <= 1'b1;
      end
    end
  end

  // A captured first failure always has at least one counted violation
  a_first_has_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    first_valid_o |-> (viol_cnt_o != '0))
    else $error("first failure captured with zero violation count");

endmodule

//--- src/rvfi_mon_axil_regs.sv
`timescale 1ns/1ps

module rvfi_mon_axil_regs #(
  parameter int CNT_W = 16
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Write address and write strobe channels, the clear register takes no data
  input  logic [7:0]                              s_axil_awaddr_i,
  input  logic                                    s_axil_awvalid_i,
  output logic                                    s_axil_awready_o,
  input  logic                                    s_axil_wvalid_i,
  output logic                                    s_axil_wready_o,
  output logic [1:0]                              s_axil_bresp_o,
  output logic                                    s_axil_bvalid_o,
  input  logic                                    s_axil_bready_i,
  input  logic [7:0]                              s_axil_araddr_i,
  input  logic                                    s_axil_arvalid_i,
  output logic                                    s_axil_arready_o,
  output logic [31:0]                             s_axil_rdata_o,
  output logic [1:0]                              s_axil_rresp_o,
  output logic                                    s_axil_rvalid_o,
  input  logic                                    s_axil_rready_i,
  // Log contents
  input  logic [rvfi_mon_trace_pkg::NUM_VIOL-1:0] status_i,
  input  logic [CNT_W-1:0]                        viol_cnt_i,
  input  logic [CNT_W-1:0]                        retire_cnt_i,
  input  logic [31:0]                             first_pc_i,
  input  rvfi_mon_trace_pkg::viol_kind_e          first_kind_i,
  input  logic                                    first_valid_i,
  output logic                                    clear_o
);
  import rvfi_mon_reg_pkg::*;

  axil_state_e state_q;
  logic        ar_hs;
  logic        wr_hs;
  logic [31:0] rd_data;
  axi_resp_e   rd_resp;
  axi_resp_e   rresp_q;
  axi_resp_e   bresp_q;

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  // AW and W go together, and a pending read takes precedence
  assign s_axil_arready_o = (state_q == IDLE);
  assign s_axil_awready_o = (state_q == IDLE) && s_axil_wvalid_i && !s_axil_arvalid_i;
  assign s_axil_wready_o  = (state_q == IDLE) && s_axil_awvalid_i && !s_axil_arvalid_i;

  assign ar_hs = s_axil_arvalid_i && s_axil_arready_o;
  assign wr_hs = s_axil_awvalid_i && s_axil_awready_o;

  assign s_axil_rvalid_o = (state_q == RDATA);
  assign s_axil_bvalid_o = (state_q == WRESP);
  assign s_axil_rresp_o  = rresp_q;
  assign s_axil_bresp_o  = bresp_q;

  // Read decode, counters are zero extended to the bus width
  always_comb begin
    rd_resp = OKAY;
    case (s_axil_araddr_i)
      REG_STATUS:     rd_data = 32'(status_i);
      REG_VIOL_CNT:   rd_data = 32'(viol_cnt_i);
      REG_RETIRE_CNT: rd_data = 32'(retire_cnt_i);
      REG_FIRST_PC:   rd_data = first_pc_i;
      // All ones marks that nothing has failed yet
      REG_FIRST_KIND: rd_data = first_valid_i ? 32'(first_kind_i) : 32'hFFFF_FFFF;
      default: begin
        rd_data = 32'h0;
        rd_resp = SLVERR;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // FSM and response registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      rresp_q <= OKAY;
      bresp_q <= OKAY;
      clear_o <= 1'b0;
    end else begin
      clear_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (ar_hs) begin
            rresp_q <= rd_resp;
            state_q <= RDATA;
          end else if (wr_hs) begin
            // Only the clear register is writable
            clear_o <= (s_axil_awaddr_i == REG_CLEAR);
            bresp_q <= (s_axil_awaddr_i == REG_CLEAR) ? OKAY : SLVERR;
            state_q <= WRESP;
          end
        end
        RDATA: begin
          if (s_axil_rready_i) begin
            state_q <= IDLE;
          end
        end
        WRESP: begin
          if (s_axil_bready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Read data is sampled once at the AR handshake
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      s_axil_rdata_o <= rd_data;
    end
  end

  // The read response holds while the master stalls
  a_rdata_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (s_axil_rvalid_o && !s_axil_rready_i) |=> (s_axil_rvalid_o && $stable(s_axil_rdata_o)))
    else $error("read response changed before it was accepted");

endmodule

//--- src/rvfi_monitor_top.sv
`timescale 1ns/1ps

module rvfi_monitor_top #(
  parameter bit DEBUG = 1'b1,
  parameter int CNT_W = 16
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Retirement trace from the core
  input  logic                                       rvfi_valid_i,
  input  logic                                       rvfi_intr_i,
  input  logic                                       rvfi_trap_exc_i,
  input  logic                                       rvfi_trap_dbg_i,
  input  logic [rvfi_mon_trace_pkg::EXC_CAUSE_W-1:0] rvfi_trap_cause_i,
  input  logic [2:0]                                 rvfi_trap_dbg_cause_i,
  input  logic [2:0]                                 rvfi_dbg_i,
  input  logic [rvfi_mon_trace_pkg::EXC_CAUSE_W-1:0] rvfi_mcause_i,
  input  logic [31:0]                                rvfi_pc_i,
  input  logic                                       debug_mode_i,
  input  logic                                       dcsr_step_i,
  input  logic                                       nmi_pending_i,
  input  logic                                       irq_ack_i,
  input  logic                                       dbg_ack_i,
  // Register port
  input  logic [7:0]                                 s_axil_awaddr_i,
  input  logic                                       s_axil_awvalid_i,
  output logic                                       s_axil_awready_o,
  input  logic                                       s_axil_wvalid_i,
  output logic                                       s_axil_wready_o,
  output logic [1:0]                                 s_axil_bresp_o,
  output logic                                       s_axil_bvalid_o,
  input  logic                                       s_axil_bready_i,
  input  logic [7:0]                                 s_axil_araddr_i,
  input  logic                                       s_axil_arvalid_i,
  output logic                                       s_axil_arready_o,
  output logic [31:0]                                s_axil_rdata_o,
  output logic [1:0]                                 s_axil_rresp_o,
  output logic                                       s_axil_rvalid_o,
  input  logic                                       s_axil_rready_i
);
  import rvfi_mon_trace_pkg::*;

  logic [NUM_VIOL-1:0] viol_trap;
  logic [NUM_VIOL-1:0] viol_ack;
  logic [NUM_VIOL-1:0] status;
  logic [CNT_W-1:0]    viol_cnt;
  logic [CNT_W-1:0]    retire_cnt;
  logic [31:0]         first_pc;
  viol_kind_e          first_kind;
  logic                first_valid;
  logic                clear;

  // The two checkers own disjoint bits, so the merge is a plain OR
  wire [NUM_VIOL-1:0] viol_all = viol_trap | viol_ack;

  rvfi_trap_checker #(
    .DEBUG (DEBUG)
  ) u_trap_checker (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .rvfi_valid_i          (rvfi_valid_i),
    .rvfi_intr_i           (rvfi_intr_i),
    .rvfi_trap_exc_i       (rvfi_trap_exc_i),
    .rvfi_trap_dbg_i       (rvfi_trap_dbg_i),
    .rvfi_trap_cause_i     (rvfi_trap_cause_i),
    .rvfi_trap_dbg_cause_i (rvfi_trap_dbg_cause_i),
    .rvfi_dbg_i            (rvfi_dbg_i),
    .rvfi_mcause_i         (rvfi_mcause_i),
    .debug_mode_i          (debug_mode_i),
    .dcsr_step_i           (dcsr_step_i),
    .nmi_pending_i         (nmi_pending_i),
    .viol_o                (viol_trap)
  );

  rvfi_ack_tracker #(
    .DEBUG (DEBUG)
  ) u_ack_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rvfi_valid_i (rvfi_valid_i),
    .rvfi_intr_i  (rvfi_intr_i),
    .rvfi_dbg_i   (rvfi_dbg_i),
    .irq_ack_i    (irq_ack_i),
    .dbg_ack_i    (dbg_ack_i),
    .viol_o       (viol_ack)
  );

  rvfi_violation_log #(
    .CNT_W (CNT_W)
  ) u_log (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .viol_i        (viol_all),
    .retire_i      (rvfi_valid_i),
    .pc_i          (rvfi_pc_i),
    .clear_i       (clear),
    .status_o      (status),
    .viol_cnt_o    (viol_cnt),
    .retire_cnt_o  (retire_cnt),
    .first_pc_o    (first_pc),
    .first_kind_o  (first_kind),
    .first_valid_o (first_valid)
  );

  rvfi_mon_axil_regs #(
    .CNT_W (CNT_W)
  ) u_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .status_i         (status),
    .viol_cnt_i       (viol_cnt),
    .retire_cnt_i     (retire_cnt),
    .first_pc_i       (first_pc),
    .first_kind_i     (first_kind),
    .first_valid_i    (first_valid),
    .clear_o          (clear)
  );

endmodule

//--- tests/tb_rvfi_monitor_top.sv
`timescale 1ns/1ps

module tb_rvfi_monitor_top;

  localparam int CNT_W = 16;

  logic        clk_i;
  logic        rst_ni;
  logic        rvfi_valid_i;
  logic        rvfi_intr_i;
  logic        rvfi_trap_exc_i;
  logic        rvfi_trap_dbg_i;
  logic [5:0]  rvfi_trap_cause_i;
  logic [2:0]  rvfi_trap_dbg_cause_i;
  logic [2:0]  rvfi_dbg_i;
  logic [5:0]  rvfi_mcause_i;
  logic [31:0] rvfi_pc_i;
  logic        debug_mode_i;
  logic        dcsr_step_i;
  logic        nmi_pending_i;
  logic        irq_ack_i;
  logic        dbg_ack_i;
  logic [7:0]  s_axil_awaddr_i;
  logic        s_axil_awvalid_i;
  logic        s_axil_awready_o;
  logic        s_axil_wvalid_i;
  logic        s_axil_wready_o;
  logic [1:0]  s_axil_bresp_o;
  logic        s_axil_bvalid_o;
  logic        s_axil_bready_i;
  logic [7:0]  s_axil_araddr_i;
  logic        s_axil_arvalid_i;
  logic        s_axil_arready_o;
  logic [31:0] s_axil_rdata_o;
  logic [1:0]  s_axil_rresp_o;
  logic        s_axil_rvalid_o;
  logic        s_axil_rready_i;

  // Golden file parsing state
  integer              fd;
  integer              rc;
  integer              seed;
  integer              err_cnt;
  int                  n_lines;
  int                  n_idle;
  int                  cycle_cnt;
  int                  cycle_limit;
  logic [63:0]         cmd;
  logic [8*256-1:0]    line;
  logic [31:0]         fld [12];
  logic [31:0]         addr;
  logic [31:0]         exp_data;
  logic [31:0]         exp_resp;

  rvfi_monitor_top #(
    .DEBUG (1'b1),
    .CNT_W (CNT_W)
  ) UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // The hang guard limit scales with the golden file length
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  //////////////////////////////////////////////////
  // Checking and failure reporting
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      err_cnt = err_cnt + 1;
      $display("Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "register value mismatch");
    end
  endtask

  task automatic report_failure(input string msg);
    err_cnt = err_cnt + 1;
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "golden file problem");
  endtask

  //////////////////////////////////////////////////
  // Trace side drivers
  //////////////////////////////////////////////////

  // Applies one cycle of trace inputs on the rising edge
  task automatic drive_trace(input logic valid, input logic intr, input logic exc,
                             input logic dbg_trap, input logic [5:0] cause,
                             input logic [2:0] dbg_cause, input logic [2:0] dbg,
                             input logic [5:0] mcause, input logic [31:0] pc,
                             input logic dmode, input logic step, input logic nmi,
                             input logic irq_ack, input logic dbg_ack);
    @(posedge clk_i);
    rvfi_valid_i          <= valid;
    rvfi_intr_i           <= intr;
    rvfi_trap_exc_i       <= exc;
    rvfi_trap_dbg_i       <= dbg_trap;
    rvfi_trap_cause_i     <= cause;
    rvfi_trap_dbg_cause_i <= dbg_cause;
    rvfi_dbg_i            <= dbg;
    rvfi_mcause_i         <= mcause;
    rvfi_pc_i             <= pc;
    debug_mode_i          <= dmode;
    dcsr_step_i           <= step;
    nmi_pending_i         <= nmi;
    irq_ack_i             <= irq_ack;
    dbg_ack_i             <= dbg_ack;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      drive_trace(0, 0, 0, 0, '0, '0, '0, '0, '0, 0, 0, 0, 0, 0);
    end
  endtask

  task automatic pulse_ack(input logic irq, input logic dbg);
    drive_trace(0, 0, 0, 0, '0, '0, '0, '0, '0, 0, 0, 0, irq, dbg);
  endtask

  //////////////////////////////////////////////////
  // AXI4-Lite master
  //////////////////////////////////////////////////

  // The idle cycles let the two-cycle log latency pass before the read
  task automatic axi_read(input logic [7:0] raddr, input logic [31:0] want_data,
                          input logic [1:0] want_resp);
    int          stall;
    logic [31:0] got_data;
    logic [1:0]  got_resp;
    idle_cycles(2);
    stall = $unsigned($random(seed)) % 4;
    @(posedge clk_i);
    s_axil_araddr_i  <= raddr;
    s_axil_arvalid_i <= 1'b1;
    do @(posedge clk_i); while (!s_axil_arready_o);
    s_axil_arvalid_i <= 1'b0;
    // Back-pressure on the read response for a random number of cycles
    repeat (stall) @(posedge clk_i);
    s_axil_rready_i <= 1'b1;
    do @(posedge clk_i); while (!s_axil_rvalid_o);
    got_data = s_axil_rdata_o;
    got_resp = s_axil_rresp_o;
    s_axil_rready_i <= 1'b0;
    check_value($sformatf("s_axil_rdata_o at 0x%02h", raddr), got_data, want_data);
    check_value($sformatf("s_axil_rresp_o at 0x%02h", raddr), {30'b0, got_resp},
                {30'b0, want_resp});
  endtask

  task automatic axi_write(input logic [7:0] waddr, input logic [1:0] want_resp);
    int         stall;
    logic [1:0] got_resp;
    idle_cycles(1);
    stall = $unsigned($random(seed)) % 4;
    @(posedge clk_i);
    s_axil_awaddr_i  <= waddr;
    s_axil_awvalid_i <= 1'b1;
    s_axil_wvalid_i  <= 1'b1;
    do @(posedge clk_i); while (!s_axil_awready_o);
    // AW and W are accepted in the same cycle
    check_value("s_axil_wready_o", {31'b0, s_axil_wready_o}, 32'h1);
    s_axil_awvalid_i <= 1'b0;
    s_axil_wvalid_i  <= 1'b0;
    repeat (stall) @(posedge clk_i);
    s_axil_bready_i <= 1'b1;
    do @(posedge clk_i); while (!s_axil_bvalid_o);
    got_resp = s_axil_bresp_o;
    s_axil_bready_i <= 1'b0;
    check_value($sformatf("s_axil_bresp_o at 0x%02h", waddr), {30'b0, got_resp},
                {30'b0, want_resp});
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    seed                  = 32'h4003277b;
    err_cnt               = 0;
    cycle_cnt             = 0;
    cycle_limit           = 0;
    n_lines               = 0;
    rst_ni                = 1'b0;
    rvfi_valid_i          = 1'b0;
    rvfi_intr_i           = 1'b0;
    rvfi_trap_exc_i       = 1'b0;
    rvfi_trap_dbg_i       = 1'b0;
    rvfi_trap_cause_i     = '0;
    rvfi_trap_dbg_cause_i = '0;
    rvfi_dbg_i            = '0;
    rvfi_mcause_i         = '0;
    rvfi_pc_i             = '0;
    debug_mode_i          = 1'b0;
    dcsr_step_i           = 1'b0;
    nmi_pending_i         = 1'b0;
    irq_ack_i             = 1'b0;
    dbg_ack_i             = 1'b0;
    s_axil_awaddr_i       = '0;
    s_axil_awvalid_i      = 1'b0;
    s_axil_wvalid_i       = 1'b0;
    s_axil_bready_i       = 1'b0;
    s_axil_araddr_i       = '0;
    s_axil_arvalid_i      = 1'b0;
    s_axil_rready_i       = 1'b0;

    // First pass only counts lines to size the hang guard
    fd = $fopen("tests/rvfi_monitor_golden.txt", "r");
    if (fd == 0) begin
      report_failure("Could not open the golden file tests/rvfi_monitor_golden.txt");
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 0) n_lines = n_lines + 1;
    end
    $fclose(fd);
    cycle_limit = 40 * n_lines;
    fd = $fopen("tests/rvfi_monitor_golden.txt", "r");

    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd[7:0] == "#") begin
        rc = $fgets(line, fd);
      end else if (cmd[7:0] == "T") begin
        rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                     fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9], fld[10],
                     fld[11]);
        if (rc != 12) report_failure("A trace record in the golden file is incomplete");
        else drive_trace(fld[0][0], fld[1][0], fld[2][0], fld[3][0], fld[4][5:0],
                         fld[5][2:0], fld[6][2:0], fld[7][5:0], fld[8], fld[9][0],
                         fld[10][0], fld[11][0], 1'b0, 1'b0);
      end else if (cmd[7:0] == "I") begin
        rc = $fscanf(fd, "%d", n_idle);
        if (rc != 1) report_failure("An idle command in the golden file has no count");
        else idle_cycles(n_idle);
      end else if (cmd[7:0] == "Q") begin
        pulse_ack(1'b1, 1'b0);
      end else if (cmd[7:0] == "D") begin
        pulse_ack(1'b0, 1'b1);
      end else if (cmd[7:0] == "R") begin
        rc = $fscanf(fd, "%h %h %h", addr, exp_data, exp_resp);
        if (rc != 3) report_failure("A read command in the golden file is incomplete");
        else axi_read(addr[7:0], exp_data, exp_resp[1:0]);
      end else if (cmd[7:0] == "W") begin
        rc = $fscanf(fd, "%h %h", addr, exp_resp);
        if (rc != 2) report_failure("A write command in the golden file is incomplete");
        else axi_write(addr[7:0], exp_resp[1:0]);
      end else begin
        report_failure("The golden file holds a command that is not known");
      end
    end
    $fclose(fd);

    idle_cycles(2);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- rvfi_monitor_top.f
src/rvfi_mon_trace_pkg.sv
src/rvfi_mon_reg_pkg.sv
src/rvfi_trap_checker.sv
src/rvfi_ack_tracker.sv
src/rvfi_violation_log.sv
src/rvfi_mon_axil_regs.sv
src/rvfi_monitor_top.sv
tests/tb_rvfi_monitor_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the retirement-trace monitor testbench with Verilator.
# Exits non-zero when the build fails, the run fails or the log reports a failure.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rvfi_monitor_top \
  -f rvfi_monitor_top.f \
  -Mdir "$OBJ_DIR" -o sim_bin
if [ $? -ne 0 ]; then
  echo "FAIL: Verilator build did not complete"
  exit 1
fi

"./$OBJ_DIR/sim_bin" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "FAIL: simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  echo "FAIL: testbench reported a failure, see $LOG"
  exit 1
fi

echo "PASS: see $LOG"
exit 0

//--- tests/rvfi_monitor_golden.txt
# T valid intr exc dbg cause dbg_cause rvfi_dbg mcause pc debug_mode step nmi | I cycles
# Q irq ack | D dbg ack | R addr data resp | W addr resp (hex except the I count)
T 1 0 0 0 00 0 0 00 00000100 0 0 0
T 1 0 0 0 00 0 0 00 00000104 0 0 0
T 1 0 1 0 0b 0 0 00 00000108 0 0 0
T 1 1 0 0 00 0 0 0b 00000200 0 0 0
T 1 0 0 0 00 0 0 00 00000204 0 0 0
T 1 0 0 0 00 0 0 00 00000208 0 0 0
T 1 0 0 0 00 0 0 00 0000020c 0 0 0
T 1 0 0 0 00 0 0 00 00000210 0 0 0
R 00 00000000 0
R 04 00000000 0
R 08 00000008 0
R 10 ffffffff 0
# Trap without interrupt and with wrong mcause, then the same under debug mode
T 1 0 1 0 05 0 0 00 00000300 0 0 0
T 1 0 0 0 00 0 0 02 00000304 0 0 0
T 1 0 1 0 05 0 0 00 00000308 0 0 0
T 0 0 0 0 00 0 0 00 00000000 1 0 0
T 1 0 0 0 00 0 0 02 0000030c 0 0 0
I 3
R 00 00000003 0
R 04 00000002 0
R 0c 00000304 0
R 10 00000000 0
# Step trap answered by HALTREQ without ack, then exc with TRIGGER
T 1 0 1 1 03 4 0 00 00000400 0 1 0
T 1 0 0 0 00 0 3 00 00000404 0 0 0
T 1 0 1 1 03 2 0 00 00000408 1 0 0
D
T 1 1 0 0 00 0 2 03 0000040c 0 0 0
R 00 0000001f 0
R 04 00000005 0
R 08 00000010 0
# Interrupt acks, first without and then with the interrupt flag
Q
T 1 0 0 0 00 0 0 00 00000500 0 0 0
Q
T 1 1 0 0 00 0 0 00 00000504 0 0 0
R 00 0000003f 0
R 04 00000006 0
R 08 00000012 0
R 0c 00000304 0
# Clear, then a rejected write and an unmapped read
W 14 0
R 00 00000000 0
R 04 00000000 0
R 08 00000000 0
R 0c 00000000 0
R 10 ffffffff 0
W 04 2
R 20 00000000 2
